/* project.f */
+incdir+dv
hw/ex_isa_pkg.sv
hw/ex_bus_pkg.sv
hw/pipe_stage.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_result.sv
hw/ex_unit.sv
dv/ex_unit_tb.sv

/* Bender.yml */
package:
  name: ex_unit

sources:
  - files:
      - hw/ex_isa_pkg.sv
      - hw/ex_bus_pkg.sv
      - hw/pipe_stage.sv
      - hw/ex_decode.sv
      - hw/ex_alu.sv
      - hw/ex_result.sv
      - hw/ex_unit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ex_unit_tb.sv

/* dv/ex_unit_tests.svh */
// directed tests for ex_unit; each task starts and ends 1 ns after a rising edge

task automatic logic_shift_ops;
    int              amt[4] = '{0, 1, 13, 31};
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < 4; i++) begin
        a = $urandom;
        b = $urandom;
        send_op(FN_AND, a, b);
        send_op(FN_OR, a, b);
        send_op(FN_XOR, a, b);
        send_op(FN_NOR, a, b);
    end
    for (int i = 0; i < 4; i++) begin
        a = ($urandom & 32'hFFFF_FFE0) | amt[i];  // upper bits must be ignored
        b = $urandom | 32'h8000_0000;             // negative, so SRA fills ones
        send_op(FN_SLL, a, b);
        send_op(FN_SRL, a, b);
        send_op(FN_SRA, a, b);
    end
    wait_drain();
endtask

task automatic arith_ops;
    // signed overflow edges and one pair that stays in range
    logic [XLEN-1:0] pa[5] = '{32'h7FFF_FFFF, 32'h8000_0000, 32'h8000_0000, 32'h7FFF_FFFF,
                               32'h7FFF_FFFE};
    logic [XLEN-1:0] pb[5] = '{32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF,
                               32'h0000_0001};
    for (int i = 0; i < 5; i++) begin
        send_op(FN_ADD, pa[i], pb[i]);
        send_op(FN_ADDU, pa[i], pb[i]);
        send_op(FN_SUB, pa[i], pb[i]);
        send_op(FN_SUBU, pa[i], pb[i]);
        send_op(FN_SLT, pa[i], pb[i]);
        send_op(FN_SLTU, pa[i], pb[i]);
    end
    wait_drain();
endtask

task automatic count_mul_ops;
    int bits[4] = '{0, 5, 17, 31};
    send_op(FN_CLZ, 32'h0, 32'h0);
    send_op(FN_CLO, 32'h0, 32'h0);
    send_op(FN_CLZ, 32'hFFFF_FFFF, 32'h0);
    send_op(FN_CLO, 32'hFFFF_FFFF, 32'h0);
    for (int i = 0; i < 4; i++) begin
        send_op(FN_CLZ, 32'h1 << bits[i], 32'h0);
        send_op(FN_CLO, ~(32'h1 << bits[i]), 32'h0);
    end
    send_op(FN_MUL, -32'sd3, 32'd7);
    send_op(FN_MUL, 32'd5, -32'sd9);
    send_op(FN_MUL, -32'sd1, -32'sd1);
    send_op(FN_MUL, $urandom, $urandom);
    wait_drain();
endtask

task automatic hilo_moves;
    send_op(FN_MULT, -32'sd5, 32'd123456);
    send_op(FN_MFHI, $urandom, $urandom);
    send_op(FN_MFLO, $urandom, $urandom);
    send_op(FN_MULTU, 32'hFFFF_FFFF, 32'h2);
    send_op(FN_MFHI, $urandom, $urandom);
    send_op(FN_MFLO, $urandom, $urandom);
    send_op(FN_MTHI, 32'hDEAD_BEEF, $urandom);
    send_op(FN_MFHI, $urandom, $urandom);
    send_op(FN_MFLO, $urandom, $urandom);  // lo untouched by MTHI
    send_op(FN_MTLO, 32'h1234_5678, $urandom);
    send_op(FN_MFHI, $urandom, $urandom);
    send_op(FN_MFLO, $urandom, $urandom);
    wait_drain();
endtask

task automatic backpressure_run;
    logic [6:0] ops[10] = '{FN_ADDU, FN_SUB, FN_XOR, FN_SRA, FN_CLZ, FN_MUL, FN_MULT,
                            FN_MFLO, FN_MTHI, FN_MFHI};
    logic       done;
    done = 1'b0;
    fork
        begin
            for (int i = 0; i < 40; i++) begin
                send_op(ops[$urandom % 10], $urandom, $urandom);
            end
            wait_drain();
            done = 1'b1;
        end
        begin
            while (!done) begin
                wb_ready_i = 1'($urandom);
                @(posedge clk);
                #1;
            end
        end
    join
    wb_ready_i = 1'b1;
endtask

task automatic reset_and_illegal;
    issue_t stuck;
    stuck.func = FN_MTHI;
    stuck.rd   = 5'd1;
    stuck.wreg = 1'b1;
    stuck.op_a = 32'hFFFF_FFFF;
    stuck.op_b = '0;
    // two items held behind a stalled writeback port, HI set to ones
    wb_ready_i    = 1'b0;
    issue_i       = stuck;
    issue_valid_i = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    issue_valid_i = 1'b0;
    assert (wb_valid_o && !issue_ready_o)
        else fail_run("stage did not fill behind a stalled writeback port");
    apply_reset(16);
    wb_ready_i = 1'b1;
    assert (!wb_valid_o && issue_ready_o)
        else fail_run($sformatf("mismatch at %0t ns: after reset wb_valid_o %b issue_ready_o %b",
                                $time, wb_valid_o, issue_ready_o));
    send_op(FN_MFHI, $urandom, $urandom);  // HI cleared by reset
    send_op(7'h01, $urandom, $urandom);
    send_op(7'h2C, $urandom, $urandom);
    send_op(7'h41, $urandom, $urandom);
    send_op(7'h7F, $urandom, $urandom);
    wait_drain();
endtask

/* dv/ex_unit_tb.sv */
// testbench for ex_unit; stops at the first error, the reference model keeps its own HI/LO copy
`timescale 1ns/1ps

module ex_unit_tb;
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    logic            clk;
    logic            reset_i;
    logic            issue_valid_i;
    logic            issue_ready_o;
    issue_t          issue_i;
    logic            wb_valid_o;
    logic            wb_ready_i;
    wb_t             wb_o;

    wb_t             exp_q[$];  // expected writebacks in issue order
    wb_t             exp_wb;
    wb_t             held_wb;
    logic            stalled_q;
    logic [XLEN-1:0] model_hi;
    logic [XLEN-1:0] model_lo;
    int              issued;

    ex_unit u_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_o          (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic int count_leading(input logic [XLEN-1:0] v, input logic bit_val);
        int n;
        n = 0;
        while (n < XLEN && v[XLEN-1-n] == bit_val) begin
            n++;
        end
        return n;
    endfunction

    // expected record from the function rules, HI/LO follow issue order
    function automatic wb_t predict(input issue_t it);
        wb_t                w;
        longint             full;
        logic signed [63:0] sp;
        logic [63:0]        up;
        w      = '0;
        w.rd   = it.rd;
        w.wreg = it.wreg;
        sp     = $signed(it.op_a) * $signed(it.op_b);
        up     = {32'd0, it.op_a} * {32'd0, it.op_b};
        case (it.func)
            FN_AND:  w.wdata = it.op_a & it.op_b;
            FN_OR:   w.wdata = it.op_a | it.op_b;
            FN_XOR:  w.wdata = it.op_a ^ it.op_b;
            FN_NOR:  w.wdata = ~(it.op_a | it.op_b);
            FN_SLL:  w.wdata = it.op_b << it.op_a[4:0];
            FN_SRL:  w.wdata = it.op_b >> it.op_a[4:0];
            FN_SRA:  w.wdata = $signed(it.op_b) >>> it.op_a[4:0];
            FN_ADD, FN_ADDU, FN_SUB, FN_SUBU: begin
                if (it.func inside {FN_ADD, FN_ADDU}) begin
                    full = longint'($signed(it.op_a)) + longint'($signed(it.op_b));
                end else begin
                    full = longint'($signed(it.op_a)) - longint'($signed(it.op_b));
                end
                w.wdata = full[31:0];
                // true sum outside the 32-bit signed range
                if (it.func inside {FN_ADD, FN_SUB} && full != longint'($signed(w.wdata))) begin
                    w.wreg = 1'b0;
                end
            end
            FN_SLT:  w.wdata = ($signed(it.op_a) < $signed(it.op_b)) ? 1 : 0;
            FN_SLTU: w.wdata = (it.op_a < it.op_b) ? 1 : 0;
            FN_CLZ:  w.wdata = count_leading(it.op_a, 1'b0);
            FN_CLO:  w.wdata = count_leading(it.op_a, 1'b1);
            FN_MUL:  w.wdata = sp[31:0];
            FN_MFHI: w.wdata = model_hi;
            FN_MFLO: w.wdata = model_lo;
            FN_MULT, FN_MULTU, FN_MTHI, FN_MTLO: begin
                w.wreg  = 1'b0;
                w.whilo = 1'b1;
                if (it.func == FN_MULT) begin
                    {model_hi, model_lo} = sp;
                end else if (it.func == FN_MULTU) begin
                    {model_hi, model_lo} = up;
                end else if (it.func == FN_MTHI) begin
                    model_hi = it.op_a;
                end else begin
                    model_lo = it.op_a;
                end
                w.hi = model_hi;
                w.lo = model_lo;
            end
            default: w.wreg = 1'b0;  // illegal code writes nothing
        endcase
        return w;
    endfunction

    task automatic apply_reset(input int cycles);
        reset_i  = 1'b1;
        model_hi = '0;
        model_lo = '0;
        repeat (cycles) @(posedge clk);
        #1;
        reset_i = 1'b0;
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_op(input logic [6:0] func, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
        issue_t it;
        it.func = func;
        it.rd   = 5'($urandom);
        it.wreg = 1'b1;
        it.op_a = a;
        it.op_b = b;
        exp_q.push_back(predict(it));
        issued++;
        issue_i       = it;
        issue_valid_i = 1'b1;
        do begin
            @(posedge clk);
        end while (!issue_ready_o);
        #1;
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_drain;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // monitor, also checks that a stalled record holds
    always @(posedge clk) begin
        if (reset_i) begin
            stalled_q = 1'b0;
        end else begin
            if (stalled_q) begin
                assert (wb_valid_o && wb_o === held_wb)
                    else fail_run("writeback record changed or vanished while stalled");
            end
            if (wb_valid_o && wb_ready_i) begin
                assert (exp_q.size() > 0)
                    else fail_run("writeback transfer with no item outstanding");
                exp_wb = exp_q.pop_front();
                assert (wb_o === exp_wb)
                    else fail_run($sformatf("mismatch at %0t ns: writeback exp %h got %h",
                                            $time, exp_wb, wb_o));
            end
            stalled_q = wb_valid_o && !wb_ready_i;
            held_wb   = wb_o;
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > issued * 20 + 500) begin
                fail_run($sformatf("timeout after %0d cycles with %0d items still pending",
                                   cycles, exp_q.size()));
            end
        end
    end

    `include "ex_unit_tests.svh"

    initial begin
        void'($urandom(9));
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        wb_ready_i    = 1'b1;
        stalled_q     = 1'b0;
        issued        = 0;
        apply_reset(16);
        logic_shift_ops();
        arith_ops();
        count_mul_ops();
        hilo_moves();
        backpressure_run();
        reset_and_illegal();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* hw/ex_unit.sv */
// execute stage top; two items in flight at most, issue_ready_o depends on wb_ready_i combinationally
`timescale 1ns/1ps

module ex_unit (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               issue_valid_i,
    output logic               issue_ready_o,
    input  ex_bus_pkg::issue_t issue_i,
    output logic               wb_valid_o,
    input  logic               wb_ready_i,
    output ex_bus_pkg::wb_t    wb_o
);
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    decoded_t          dec;
    logic              dec_valid;
    logic              dec_ready;
    logic [XLEN-1:0]   logic_res;
    logic [XLEN-1:0]   shift_res;
    logic [XLEN-1:0]   arith_res;
    logic [2*XLEN-1:0] prod;
    logic              wreg;

    ex_decode u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .dec_valid_o   (dec_valid),
        .dec_ready_i   (dec_ready),
        .dec_o         (dec)
    );

    ex_alu u_alu (
        .dec_i       (dec),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res),
        .arith_res_o (arith_res),
        .prod_o      (prod),
        .wreg_o      (wreg)
    );

    ex_result u_result (
        .clk         (clk),
        .reset_i     (reset_i),
        .dec_valid_i (dec_valid),
        .dec_ready_o (dec_ready),
        .dec_i       (dec),
        .logic_res_i (logic_res),
        .shift_res_i (shift_res),
        .arith_res_i (arith_res),
        .prod_i      (prod),
        .wreg_i      (wreg),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_o        (wb_o)
    );

endmodule

/* hw/ex_result.sv */
// result select and HI/LO owner; HI/LO change on accept, before the record reaches wb_o
`timescale 1ns/1ps

module ex_result (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             dec_valid_i,
    output logic                             dec_ready_o,
    input  ex_bus_pkg::decoded_t             dec_i,
    input  logic [ex_isa_pkg::XLEN-1:0]      logic_res_i,
    input  logic [ex_isa_pkg::XLEN-1:0]      shift_res_i,
    input  logic [ex_isa_pkg::XLEN-1:0]      arith_res_i,
    input  logic [2*ex_isa_pkg::XLEN-1:0]    prod_i,
    input  logic                             wreg_i,
    output logic                             wb_valid_o,
    input  logic                             wb_ready_i,
    output ex_bus_pkg::wb_t                  wb_o
);
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    wb_t             wb_d;
    logic [XLEN-1:0] hi_q;
    logic [XLEN-1:0] lo_q;
    logic            accept;

    assign accept = dec_valid_i && dec_ready_o;

    always_comb begin
        wb_d.rd    = dec_i.rd;
        wb_d.wreg  = wreg_i;
        wb_d.whilo = 1'b0;
        wb_d.hi    = '0;
        wb_d.lo    = '0;
        case (dec_i.sel)
            RES_LOGIC: wb_d.wdata = logic_res_i;
            RES_SHIFT: wb_d.wdata = shift_res_i;
            RES_ARITH: wb_d.wdata = arith_res_i;
            RES_MUL:   wb_d.wdata = prod_i[XLEN-1:0];  // low word only
            RES_MOVE: begin
                if (dec_i.op == OP_MFHI) begin
                    wb_d.wdata = hi_q;
                end else if (dec_i.op == OP_MFLO) begin
                    wb_d.wdata = lo_q;
                end else begin
                    wb_d.wdata = '0;
                end
            end
            default:   wb_d.wdata = '0;
        endcase
        case (dec_i.op)
            OP_MULT, OP_MULTU: begin
                wb_d.whilo = 1'b1;
                wb_d.hi    = prod_i[2*XLEN-1:XLEN];
                wb_d.lo    = prod_i[XLEN-1:0];
            end
            OP_MTHI: begin
                wb_d.whilo = 1'b1;
                wb_d.hi    = dec_i.op_a;
                wb_d.lo    = lo_q;  // lo kept
            end
            OP_MTLO: begin
                wb_d.whilo = 1'b1;
                wb_d.hi    = hi_q;  // hi kept
                wb_d.lo    = dec_i.op_a;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (accept && wb_d.whilo) begin
            hi_q <= wb_d.hi;
            lo_q <= wb_d.lo;
        end
    end

    pipe_stage #(
        .payload_t (wb_t)
    ) u_wb_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (dec_valid_i),
        .in_ready_o  (dec_ready_o),
        .in_data_i   (wb_d),
        .out_valid_o (wb_valid_o),
        .out_ready_i (wb_ready_i),
        .out_data_o  (wb_o)
    );

    // decode clears wreg for every op that writes hi/lo
    a_one_target: assert property (@(posedge clk) disable iff (reset_i)
        wb_valid_o |-> !(wb_o.whilo && wb_o.wreg));

endmodule

/* hw/ex_alu.sv */
// combinational datapath; shift amount is op_a[4:0] and shifts apply to op_b, as in MIPS SLLV
`timescale 1ns/1ps

module ex_alu (
    input  ex_bus_pkg::decoded_t           dec_i,
    output logic [ex_isa_pkg::XLEN-1:0]    logic_res_o,
    output logic [ex_isa_pkg::XLEN-1:0]    shift_res_o,
    output logic [ex_isa_pkg::XLEN-1:0]    arith_res_o,
    output logic [2*ex_isa_pkg::XLEN-1:0]  prod_o,
    output logic                           wreg_o
);
    import ex_isa_pkg::*;

    localparam int CNT_W = $clog2(XLEN + 1);

    logic [$clog2(XLEN)-1:0]    shamt;
    logic                       sub_op;
    logic [XLEN-1:0]            b_mux;
    logic [XLEN:0]              sum_full;
    logic [XLEN-1:0]            sum;
    logic                       lt_s;
    logic                       lt_u;
    logic                       ovf;
    logic [CNT_W-1:0]           clz_cnt;
    logic [CNT_W-1:0]           clo_cnt;
    logic                       mul_signed;
    logic signed [XLEN:0]       mul_a;
    logic signed [XLEN:0]       mul_b;
    logic signed [2*XLEN+1:0]   mul_full;

    function automatic logic [CNT_W-1:0] lead_zeros(input logic [XLEN-1:0] v);
        logic [CNT_W-1:0] n;
        logic             found;
        n     = '0;
        found = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    always_comb begin
        case (dec_i.op)
            OP_AND:  logic_res_o = dec_i.op_a & dec_i.op_b;
            OP_OR:   logic_res_o = dec_i.op_a | dec_i.op_b;
            OP_XOR:  logic_res_o = dec_i.op_a ^ dec_i.op_b;
            OP_NOR:  logic_res_o = ~(dec_i.op_a | dec_i.op_b);
            default: logic_res_o = '0;
        endcase
    end

    assign shamt = dec_i.op_a[$clog2(XLEN)-1:0];

    always_comb begin
        case (dec_i.op)
            OP_SLL:  shift_res_o = dec_i.op_b << shamt;
            OP_SRL:  shift_res_o = dec_i.op_b >> shamt;
            OP_SRA:  shift_res_o = $signed(dec_i.op_b) >>> shamt;  // sign fill
            default: shift_res_o = '0;
        endcase
    end

    // one adder for add, sub and both compares
    assign sub_op   = dec_i.op inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU};
    assign b_mux    = sub_op ? ~dec_i.op_b : dec_i.op_b;
    assign sum_full = {1'b0, dec_i.op_a} + {1'b0, b_mux} + {{XLEN{1'b0}}, sub_op};
    assign sum      = sum_full[XLEN-1:0];
    assign lt_u     = ~sum_full[XLEN];  // borrow out
    assign lt_s     = (dec_i.op_a[XLEN-1] ^ dec_i.op_b[XLEN-1]) ? dec_i.op_a[XLEN-1]
                                                                 : sum[XLEN-1];
    assign ovf      = (dec_i.op_a[XLEN-1] == b_mux[XLEN-1]) && (sum[XLEN-1] != dec_i.op_a[XLEN-1]);
    assign wreg_o   = dec_i.wreg && !(ovf && (dec_i.op inside {OP_ADD, OP_SUB}));

    assign clz_cnt = lead_zeros(dec_i.op_a);
    assign clo_cnt = lead_zeros(~dec_i.op_a);  // leading ones are leading zeros of the inverse

    always_comb begin
        case (dec_i.op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_res_o = sum;
            OP_SLT:  arith_res_o = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: arith_res_o = {{(XLEN-1){1'b0}}, lt_u};
            OP_CLZ:  arith_res_o = {{(XLEN-CNT_W){1'b0}}, clz_cnt};
            OP_CLO:  arith_res_o = {{(XLEN-CNT_W){1'b0}}, clo_cnt};
            default: arith_res_o = '0;
        endcase
    end

    // 33x33 signed multiply covers both signed and unsigned forms
    assign mul_signed = dec_i.op != OP_MULTU;
    assign mul_a      = {mul_signed & dec_i.op_a[XLEN-1], dec_i.op_a};
    assign mul_b      = {mul_signed & dec_i.op_b[XLEN-1], dec_i.op_b};
    assign mul_full   = mul_a * mul_b;
    assign prod_o     = mul_full[2*XLEN-1:0];

endmodule

/* hw/ex_decode.sv */
// function decode with a registered output; illegal codes become a nop that writes nothing
`timescale 1ns/1ps

module ex_decode (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 issue_valid_i,
    output logic                 issue_ready_o,
    input  ex_bus_pkg::issue_t   issue_i,
    output logic                 dec_valid_o,
    input  logic                 dec_ready_i,
    output ex_bus_pkg::decoded_t dec_o
);
    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    alu_op_e  op;
    res_sel_e sel;
    decoded_t dec_d;

    always_comb begin
        case (issue_i.func)
            FN_AND:   op = OP_AND;
            FN_OR:    op = OP_OR;
            FN_XOR:   op = OP_XOR;
            FN_NOR:   op = OP_NOR;
            FN_SLL:   op = OP_SLL;
            FN_SRL:   op = OP_SRL;
            FN_SRA:   op = OP_SRA;
            FN_ADD:   op = OP_ADD;
            FN_ADDU:  op = OP_ADDU;
            FN_SUB:   op = OP_SUB;
            FN_SUBU:  op = OP_SUBU;
            FN_SLT:   op = OP_SLT;
            FN_SLTU:  op = OP_SLTU;
            FN_CLZ:   op = OP_CLZ;
            FN_CLO:   op = OP_CLO;
            FN_MUL:   op = OP_MUL;
            FN_MULT:  op = OP_MULT;
            FN_MULTU: op = OP_MULTU;
            FN_MFHI:  op = OP_MFHI;
            FN_MFLO:  op = OP_MFLO;
            FN_MTHI:  op = OP_MTHI;
            FN_MTLO:  op = OP_MTLO;
            default:  op = OP_NOP;  // illegal code
        endcase
    end

    // mult and mt* only touch hi/lo, so they sit in the none class
    always_comb begin
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR:           sel = RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:                  sel = RES_SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU, OP_CLZ, OP_CLO:         sel = RES_ARITH;
            OP_MUL:                                  sel = RES_MUL;
            OP_MFHI, OP_MFLO:                        sel = RES_MOVE;
            default:                                 sel = RES_NONE;
        endcase
    end

    always_comb begin
        dec_d.op   = op;
        dec_d.sel  = sel;
        dec_d.rd   = issue_i.rd;
        dec_d.wreg = issue_i.wreg && !(op inside {OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO});
        dec_d.op_a = issue_i.op_a;
        dec_d.op_b = issue_i.op_b;
    end

    pipe_stage #(
        .payload_t (decoded_t)
    ) u_dec_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (issue_valid_i),
        .in_ready_o  (issue_ready_o),
        .in_data_i   (dec_d),
        .out_valid_o (dec_valid_o),
        .out_ready_i (dec_ready_i),
        .out_data_o  (dec_o)
    );

endmodule

/* hw/pipe_stage.sv */
// one-entry register slice; in_ready_o follows out_ready_i combinationally, so long chains add a comb path
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    assign in_ready_o  = !valid_q || out_ready_i;  // empty, or draining this cycle
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;  // refill or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    // a stalled output keeps both its valid and its payload
    a_hold_stalled: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

/* hw/ex_bus_pkg.sv */
// payload records of the execute stage; the issue func field is raw so illegal codes can be carried
package ex_bus_pkg;

    // 77 bits
    typedef struct packed {
        logic [6:0]                  func;   // raw funct, may be illegal
        logic [4:0]                  rd;
        logic                        wreg;
        logic [ex_isa_pkg::XLEN-1:0] op_a;
        logic [ex_isa_pkg::XLEN-1:0] op_b;
    } issue_t;

    // 78 bits
    typedef struct packed {
        ex_isa_pkg::alu_op_e         op;
        ex_isa_pkg::res_sel_e        sel;
        logic [4:0]                  rd;
        logic                        wreg;
        logic [ex_isa_pkg::XLEN-1:0] op_a;
        logic [ex_isa_pkg::XLEN-1:0] op_b;
    } decoded_t;

    // 103 bits
    typedef struct packed {
        logic [4:0]                  rd;
        logic                        wreg;
        logic [ex_isa_pkg::XLEN-1:0] wdata;
        logic                        whilo;  // hi and lo are written together
        logic [ex_isa_pkg::XLEN-1:0] hi;
        logic [ex_isa_pkg::XLEN-1:0] lo;
    } wb_t;

endpackage

/* hw/ex_isa_pkg.sv */
// instruction set of the execute stage; word width is fixed at 32, other widths are unsupported
package ex_isa_pkg;

    localparam int XLEN = 32;

    // bit 6 clear is SPECIAL funct, bit 6 set is SPECIAL2
    typedef enum logic [6:0] {
        FN_SLL   = 7'h00,
        FN_SRL   = 7'h02,
        FN_SRA   = 7'h03,
        FN_MFHI  = 7'h10,
        FN_MTHI  = 7'h11,
        FN_MFLO  = 7'h12,
        FN_MTLO  = 7'h13,
        FN_MULT  = 7'h18,
        FN_MULTU = 7'h19,
        FN_ADD   = 7'h20,
        FN_ADDU  = 7'h21,
        FN_SUB   = 7'h22,
        FN_SUBU  = 7'h23,
        FN_AND   = 7'h24,
        FN_OR    = 7'h25,
        FN_XOR   = 7'h26,
        FN_NOR   = 7'h27,
        FN_SLT   = 7'h2A,
        FN_SLTU  = 7'h2B,
        FN_MUL   = 7'h42,
        FN_CLZ   = 7'h60,
        FN_CLO   = 7'h61
    } ex_func_e;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
        OP_CLZ, OP_CLO,
        OP_MUL, OP_MULT, OP_MULTU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
    } alu_op_e;

    typedef enum logic [2:0] {
        RES_NONE, RES_LOGIC, RES_SHIFT, RES_ARITH, RES_MUL, RES_MOVE
    } res_sel_e;

endpackage
